//--- Bender.yml
package:
  name: frame_sync

sources:
  - design/frame_sync_pkg.sv
  - design/pss_mode_ctrl.sv
  - design/sync_fsm.sv
  - design/symbol_counter.sv
  - design/stream_out.sv
  - design/frame_sync_top.sv
  - target: simulation
    files:
      - tb/frame_sync_asserts.sv
      - tb/frame_sync_tb.sv

//--- all.f
design/frame_sync_pkg.sv
design/pss_mode_ctrl.sv
design/sync_fsm.sv
design/symbol_counter.sv
design/stream_out.sv
design/frame_sync_top.sv
tb/frame_sync_asserts.sv
tb/frame_sync_tb.sv

//--- design/frame_sync_pkg.sv
`default_nettype none

package frame_sync_pkg;

    // numerology for a 256 point FFT at 3.84 MHz
    localparam int FFT_LEN = 256;
    localparam int CP1_LEN = 20;
    localparam int CP2_LEN = 18;
    localparam int SYM_PER_SF = 14;
    localparam int SF_PER_FRAME = 20;
    localparam int SFN_MAX = 1023;
    localparam int SYMS_BTWN_SSB = SF_PER_FRAME * SYM_PER_SF;

    // detector timing in clock cycles
    localparam int CLK_FREQ = 3840000;
    localparam int CLKS_20MS = CLK_FREQ / 50;
    localparam int CLKS_EARLY = CLK_FREQ / 10000;
    localparam int CLKS_LATE = CLK_FREQ / 10000;

    // the find window opens this many samples before the symbol end
    localparam int FIND_EARLY_SAMPLES = 4;
    localparam int LOST_SAMPLE = 3;

    // SSB pattern for case A starts at symbols 2, 8, 16 and 22
    // acquisition assumes the first one and lands on symbol 3
    localparam int SSB_START_SYM = 3;
    localparam logic [3:0][4:0] IBAR_OFFSET = {5'd20, 5'd14, 5'd6, 5'd0};

    typedef logic [31:0] sample_t;
    typedef logic [9:0]  sfn_t;
    typedef logic [4:0]  sf_num_t;
    typedef logic [3:0]  sym_num_t;
    typedef logic [4:0]  cp_len_t;
    typedef logic [8:0]  sample_cnt_t;
    typedef logic [1:0]  nid2_t;
    typedef logic [2:0]  ibar_t;
    typedef logic [8:0]  ssb_gap_t;
    typedef logic [16:0] clk_cnt_t;
    typedef logic [23:0] user_t;

    typedef enum logic [1:0] {
        PSS_SEARCH = 2'd0,
        PSS_FIND   = 2'd1,
        PSS_PAUSE  = 2'd2
    } pss_mode_e;

    typedef enum logic [1:0] {
        WAIT_FOR_SSB  = 2'd0,
        WAIT_FOR_IBAR = 2'd1,
        SYNCED        = 2'd2
    } sync_state_e;

endpackage

`default_nettype wire

//--- design/frame_sync_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sync_top
    import frame_sync_pkg::*;
(
    input  wire         clk_i,
    input  wire         reset_ni,
    input  sample_t     s_axis_in_tdata_i,
    input  wire         s_axis_in_tvalid_i,
    // N_id_2 is not forwarded, only its strobe is used
    input  nid2_t       n_id_2_i,
    input  wire         n_id_2_valid_i,
    input  ibar_t       ibar_ssb_i,
    input  wire         ibar_ssb_valid_i,
    output pss_mode_e   pss_detector_mode_o,
    output logic [15:0] missed_ssbs_o,
    output sync_state_e sync_state_o,
    output logic        ssb_start_o,
    output sample_t     m_axis_out_tdata_o,
    output user_t       m_axis_out_tuser_o,
    output logic        m_axis_out_tlast_o,
    output logic        m_axis_out_tvalid_o,
    output logic        symbol_start_o
);

    logic        start;
    logic        ibar_adj;
    ibar_t       ibar;
    logic        find;
    logic        out_gate;
    sample_cnt_t sample_cnt;
    sym_num_t    sym;
    sf_num_t     sf;
    sfn_t        sfn;
    cp_len_t     cp_len;
    logic        sym_end;
    logic        ssb_due;

    pss_mode_ctrl u_pss_mode_ctrl (
        .clk_i               (clk_i),
        .reset_ni            (reset_ni),
        .n_id_2_valid_i      (n_id_2_valid_i),
        .pss_detector_mode_o (pss_detector_mode_o),
        .missed_ssbs_o       (missed_ssbs_o)
    );

    sync_fsm u_sync_fsm (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .n_id_2_valid_i   (n_id_2_valid_i),
        .ibar_ssb_valid_i (ibar_ssb_valid_i),
        .ibar_ssb_i       (ibar_ssb_i),
        .sample_cnt_i     (sample_cnt),
        .sym_end_i        (sym_end),
        .ssb_due_i        (ssb_due),
        .valid_i          (s_axis_in_tvalid_i),
        .sync_state_o     (sync_state_o),
        .start_o          (start),
        .ibar_adj_o       (ibar_adj),
        .ibar_o           (ibar),
        .find_o           (find),
        .out_gate_o       (out_gate),
        .ssb_start_o      (ssb_start_o)
    );

    symbol_counter u_symbol_counter (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .valid_i        (s_axis_in_tvalid_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .start_i        (start),
        .ibar_adj_i     (ibar_adj),
        .ibar_i         (ibar),
        .sample_cnt_o   (sample_cnt),
        .sym_o          (sym),
        .sf_o           (sf),
        .sfn_o          (sfn),
        .cp_len_o       (cp_len),
        .sym_end_o      (sym_end),
        .ssb_due_o      (ssb_due)
    );

    stream_out u_stream_out (
        .clk_i               (clk_i),
        .reset_ni            (reset_ni),
        .tdata_i             (s_axis_in_tdata_i),
        .tvalid_i            (s_axis_in_tvalid_i),
        .gate_i              (out_gate),
        .sym_end_i           (sym_end),
        .sample_cnt_i        (sample_cnt),
        .sfn_i               (sfn),
        .sf_i                (sf),
        .sym_i               (sym),
        .cp_len_i            (cp_len),
        .sync_state_i        (sync_state_o),
        .m_axis_out_tdata_o  (m_axis_out_tdata_o),
        .m_axis_out_tuser_o  (m_axis_out_tuser_o),
        .m_axis_out_tlast_o  (m_axis_out_tlast_o),
        .m_axis_out_tvalid_o (m_axis_out_tvalid_o),
        .symbol_start_o      (symbol_start_o)
    );

endmodule

`default_nettype wire

//--- design/pss_mode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pss_mode_ctrl
    import frame_sync_pkg::*;
(
    input  wire         clk_i,
    input  wire         reset_ni,
    input  wire         n_id_2_valid_i,
    output pss_mode_e   pss_detector_mode_o,
    output logic [15:0] missed_ssbs_o
);

    pss_mode_e state_q;
    clk_cnt_t  clks_since_ssb_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= PSS_SEARCH;
            clks_since_ssb_q <= '0;
            missed_ssbs_o <= '0;
            pss_detector_mode_o <= PSS_SEARCH;
        end else begin
            // the detector sees the mode one cycle after the state
            pss_detector_mode_o <= state_q;
            case (state_q)
                PSS_SEARCH: begin
                    // any N_id_2 is accepted while searching
                    if (n_id_2_valid_i) begin
                        state_q <= PSS_PAUSE;
                        clks_since_ssb_q <= 17'd1;
                        missed_ssbs_o <= '0;
                    end
                end
                PSS_PAUSE: begin
                    // sleep until shortly before the next SSB is due
                    if (clks_since_ssb_q > clk_cnt_t'(CLKS_20MS - CLKS_EARLY)) begin
                        state_q <= PSS_FIND;
                    end
                    clks_since_ssb_q <= clks_since_ssb_q + 17'd1;
                end
                PSS_FIND: begin
                    if (n_id_2_valid_i) begin
                        state_q <= PSS_PAUSE;
                        clks_since_ssb_q <= 17'd1;
                    end else if (clks_since_ssb_q > clk_cnt_t'(CLKS_20MS + CLKS_LATE)) begin
                        // the SSB did not show up inside the window
                        state_q <= PSS_SEARCH;
                        missed_ssbs_o <= missed_ssbs_o + 16'd1;
                    end else begin
                        clks_since_ssb_q <= clks_since_ssb_q + 17'd1;
                    end
                end
                default: begin
                    state_q <= PSS_SEARCH;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/stream_out.sv
`timescale 1ns/1ps
`default_nettype none

module stream_out
    import frame_sync_pkg::*;
(
    input  wire         clk_i,
    input  wire         reset_ni,
    input  sample_t     tdata_i,
    input  wire         tvalid_i,
    input  wire         gate_i,
    input  wire         sym_end_i,
    input  sample_cnt_t sample_cnt_i,
    input  sfn_t        sfn_i,
    input  sf_num_t     sf_i,
    input  sym_num_t    sym_i,
    input  cp_len_t     cp_len_i,
    input  sync_state_e sync_state_i,
    output sample_t     m_axis_out_tdata_o,
    output user_t       m_axis_out_tuser_o,
    output logic        m_axis_out_tlast_o,
    output logic        m_axis_out_tvalid_o,
    output logic        symbol_start_o
);

    sample_t tdata_q;
    user_t   tuser_q;
    logic    tvalid_q;
    logic    tlast_q;
    // blocks a second strobe until sample 1 has been seen
    logic    fired_q;

    always_ff @(posedge clk_i) begin
        tdata_q <= tdata_i;
        tuser_q <= {sfn_i, sf_i, sym_i, cp_len_i};
        m_axis_out_tdata_o <= tdata_q;
        m_axis_out_tuser_o <= tuser_q;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            tvalid_q <= 1'b0;
            tlast_q <= 1'b0;
            m_axis_out_tvalid_o <= 1'b0;
            m_axis_out_tlast_o <= 1'b0;
        end else begin
            tvalid_q <= tvalid_i && gate_i;
            tlast_q <= sym_end_i && gate_i;
            m_axis_out_tvalid_o <= tvalid_q;
            m_axis_out_tlast_o <= tlast_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            symbol_start_o <= 1'b0;
            fired_q <= 1'b0;
        end else begin
            symbol_start_o <= 1'b0;
            if (!fired_q) begin
                if (tvalid_i && (sample_cnt_i == '0) && (sync_state_i != WAIT_FOR_SSB)) begin
                    symbol_start_o <= 1'b1;
                    fired_q <= 1'b1;
                end
            end else if ((sample_cnt_i == 9'd1) || (sync_state_i == WAIT_FOR_SSB)) begin
                fired_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/symbol_counter.sv
`timescale 1ns/1ps
`default_nettype none

module symbol_counter
    import frame_sync_pkg::*;
(
    input  wire         clk_i,
    input  wire         reset_ni,
    input  wire         valid_i,
    input  wire         n_id_2_valid_i,
    input  wire         start_i,
    input  wire         ibar_adj_i,
    input  ibar_t       ibar_i,
    output sample_cnt_t sample_cnt_o,
    output sym_num_t    sym_o,
    output sf_num_t     sf_o,
    output sfn_t        sfn_o,
    output cp_len_t     cp_len_o,
    output logic        sym_end_o,
    output logic        ssb_due_o
);

    // symbols 0 and 7 of a subframe carry the long CP
    function automatic cp_len_t cp_of(input sym_num_t sym);
        if ((sym == 4'd0) || (sym == 4'd7)) begin
            return cp_len_t'(CP1_LEN);
        end
        return cp_len_t'(CP2_LEN);
    endfunction

    ssb_gap_t    syms_since_ssb_q;
    sample_cnt_t sym_last;
    logic [4:0]  sym_inc;
    logic [5:0]  sym_sum;
    logic [1:0]  sf_carry;
    logic [5:0]  sf_sum;
    sym_num_t    sym_next;
    sf_num_t     sf_next;
    sfn_t        sfn_next;

    assign sym_last = sample_cnt_t'(FFT_LEN) + sample_cnt_t'(cp_len_o) - 9'd1;

    // greater-or-equal keeps the count bounded if a CP change shortens the symbol
    assign sym_end_o = valid_i && (sample_cnt_o >= sym_last);
    assign ssb_due_o = valid_i
                       && (sample_cnt_o == sample_cnt_t'(FFT_LEN) + sample_cnt_t'(cp_len_o)
                           - sample_cnt_t'(FIND_EARLY_SAMPLES))
                       && (syms_since_ssb_q == ssb_gap_t'(SYMS_BTWN_SSB - 1));

    // a symbol end and an ibar correction in the same cycle add up
    always_comb begin
        sym_inc = 5'd0;
        if (sym_end_o) begin
            sym_inc = 5'd1;
        end
        if (ibar_adj_i) begin
            sym_inc = sym_inc + IBAR_OFFSET[ibar_i[1:0]];
        end
        sym_sum = {2'b00, sym_o} + {1'b0, sym_inc};
        if (sym_sum >= 6'(2 * SYM_PER_SF)) begin
            sym_next = sym_num_t'(sym_sum - 6'(2 * SYM_PER_SF));
            sf_carry = 2'd2;
        end else if (sym_sum >= 6'(SYM_PER_SF)) begin
            sym_next = sym_num_t'(sym_sum - 6'(SYM_PER_SF));
            sf_carry = 2'd1;
        end else begin
            sym_next = sym_num_t'(sym_sum);
            sf_carry = 2'd0;
        end
        sf_sum = {1'b0, sf_o} + {4'd0, sf_carry};
        if (sf_sum >= 6'(SF_PER_FRAME)) begin
            sf_next = sf_num_t'(sf_sum - 6'(SF_PER_FRAME));
            sfn_next = (sfn_o == sfn_t'(SFN_MAX - 1)) ? '0 : sfn_o + 10'd1;
        end else begin
            sf_next = sf_num_t'(sf_sum);
            sfn_next = sfn_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt_o <= '0;
            sym_o <= '0;
            sf_o <= '0;
            sfn_o <= '0;
            cp_len_o <= cp_len_t'(CP1_LEN);
            syms_since_ssb_q <= '0;
        end else begin
            if (start_i) begin
                // the SSB sample itself was sample 0 of the symbol
                sample_cnt_o <= 9'd1;
                sym_o <= sym_num_t'(SSB_START_SYM);
                cp_len_o <= cp_of(sym_num_t'(SSB_START_SYM));
            end else begin
                if (valid_i) begin
                    sample_cnt_o <= sym_end_o ? '0 : sample_cnt_o + 9'd1;
                end
                if (sym_end_o || ibar_adj_i) begin
                    sym_o <= sym_next;
                    sf_o <= sf_next;
                    sfn_o <= sfn_next;
                    cp_len_o <= cp_of(sym_next);
                end
            end
            if (n_id_2_valid_i) begin
                syms_since_ssb_q <= '0;
            end else if (sym_end_o) begin
                syms_since_ssb_q <= syms_since_ssb_q + 9'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sync_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fsm
    import frame_sync_pkg::*;
(
    input  wire         clk_i,
    input  wire         reset_ni,
    input  wire         n_id_2_valid_i,
    input  wire         ibar_ssb_valid_i,
    input  ibar_t       ibar_ssb_i,
    input  sample_cnt_t sample_cnt_i,
    input  wire         sym_end_i,
    input  wire         ssb_due_i,
    input  wire         valid_i,
    output sync_state_e sync_state_o,
    output logic        start_o,
    output logic        ibar_adj_o,
    output ibar_t       ibar_o,
    output logic        find_o,
    output logic        out_gate_o,
    output logic        ssb_start_o
);

    sync_state_e state_q;
    logic        find_q;
    // set once the symbol before the SSB has ended inside the window
    logic        past_end_q;
    logic        lost;

    assign sync_state_o = state_q;
    assign find_o = find_q;

    // commands go straight to the counter so it updates in the next cycle
    assign start_o = (state_q == WAIT_FOR_SSB) && n_id_2_valid_i;
    assign ibar_adj_o = (state_q == WAIT_FOR_IBAR) && ibar_ssb_valid_i;
    assign ibar_o = ibar_ssb_i;

    assign lost = find_q && !n_id_2_valid_i && valid_i
                  && (sample_cnt_i == sample_cnt_t'(LOST_SAMPLE));

    always_comb begin
        out_gate_o = 1'b0;
        case (state_q)
            WAIT_FOR_IBAR: out_gate_o = 1'b1;
            SYNCED: begin
                // the tail of the symbol before the SSB still passes
                if (!find_q) begin
                    out_gate_o = 1'b1;
                end else begin
                    out_gate_o = n_id_2_valid_i || !past_end_q;
                end
            end
            default: out_gate_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= WAIT_FOR_SSB;
            find_q <= 1'b0;
            past_end_q <= 1'b0;
            ssb_start_o <= 1'b0;
        end else begin
            // SSBs outside the window are ignored once synced
            ssb_start_o <= n_id_2_valid_i && ((state_q != SYNCED) || find_q);
            case (state_q)
                WAIT_FOR_SSB: begin
                    find_q <= 1'b0;
                    if (n_id_2_valid_i) begin
                        state_q <= WAIT_FOR_IBAR;
                    end
                end
                WAIT_FOR_IBAR: begin
                    if (ibar_ssb_valid_i) begin
                        state_q <= SYNCED;
                    end
                end
                SYNCED: begin
                    if (find_q) begin
                        if (n_id_2_valid_i) begin
                            find_q <= 1'b0;
                        end else if (lost) begin
                            find_q <= 1'b0;
                            state_q <= WAIT_FOR_SSB;
                        end
                        if (sym_end_i) begin
                            past_end_q <= 1'b1;
                        end
                    end else if (ssb_due_i) begin
                        find_q <= 1'b1;
                        past_end_q <= 1'b0;
                    end
                end
                default: begin
                    state_q <= WAIT_FOR_SSB;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tb/frame_sync_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sync_asserts
    import frame_sync_pkg::*;
(
    input  wire         clk_i,
    input  wire         reset_ni,
    input  sample_t     s_axis_in_tdata_i,
    input  wire         s_axis_in_tvalid_i,
    input  wire         n_id_2_valid_i,
    input  ibar_t       ibar_ssb_i,
    input  wire         ibar_ssb_valid_i,
    input  pss_mode_e   pss_detector_mode_o,
    input  wire [15:0]  missed_ssbs_o,
    input  sync_state_e sync_state_o,
    input  wire         ssb_start_o,
    input  sample_t     m_axis_out_tdata_o,
    input  user_t       m_axis_out_tuser_o,
    input  wire         m_axis_out_tlast_o,
    input  wire         m_axis_out_tvalid_o,
    input  wire         symbol_start_o,
    input  wire         find_i,
    input  sample_cnt_t sample_cnt_i,
    input  sym_num_t    sym_i,
    input  sf_num_t     sf_i,
    input  sfn_t        sfn_i
);

    int          fail_cnt = 0;
    int          seen_q;
    logic        clean_q;
    logic        first_q;
    logic [18:0] next_id_q;

    // moves a {sfn, subframe, symbol} position forward by n symbols
    function automatic logic [18:0] add_syms(input sfn_t sfn, input sf_num_t sf,
                                             input sym_num_t sym, input int n);
        int s;
        int f;
        int fr;
        s = int'(sym) + n;
        f = int'(sf);
        fr = int'(sfn);
        while (s >= SYM_PER_SF) begin
            s = s - SYM_PER_SF;
            f = f + 1;
            if (f == SF_PER_FRAME) begin
                f = 0;
                fr = (fr + 1) % SFN_MAX;
            end
        end
        return {fr[9:0], f[4:0], s[3:0]};
    endfunction

    function automatic int cp_for(input sym_num_t sym);
        if ((sym == 4'd0) || (sym == 4'd7)) begin
            return CP1_LEN;
        end
        return CP2_LEN;
    endfunction

    // a symbol is only judged when it started after a tlast seen in SYNCED
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            seen_q <= 0;
            clean_q <= 1'b0;
            first_q <= 1'b0;
            next_id_q <= '0;
        end else begin
            if (m_axis_out_tvalid_o) begin
                if (m_axis_out_tlast_o) begin
                    seen_q <= 0;
                    first_q <= 1'b1;
                    next_id_q <= add_syms(m_axis_out_tuser_o[23:14], m_axis_out_tuser_o[13:9],
                                          m_axis_out_tuser_o[8:5], 1);
                end else begin
                    seen_q <= seen_q + 1;
                    first_q <= 1'b0;
                end
            end
            if (sync_state_o != SYNCED) begin
                clean_q <= 1'b0;
            end else if (m_axis_out_tvalid_o && m_axis_out_tlast_o) begin
                clean_q <= 1'b1;
            end
        end
    end

    reset_values: assert property (@(posedge clk_i) $rose(reset_ni) |->
        !m_axis_out_tvalid_o && !m_axis_out_tlast_o && !ssb_start_o && !symbol_start_o
        && (pss_detector_mode_o == PSS_SEARCH) && (sync_state_o == WAIT_FOR_SSB)
        && (missed_ssbs_o == 16'd0))
        else begin
            fail_cnt++;
            $error("outputs not at reset values");
        end

    // each sample leaves the output two cycles after it came in
    data_delay: assert property (@(posedge clk_i) disable iff (!reset_ni)
        m_axis_out_tvalid_o |-> $past(s_axis_in_tvalid_i, 2)
        && (m_axis_out_tdata_o == $past(s_axis_in_tdata_i, 2)))
        else begin
            fail_cnt++;
            $error("output sample does not match the input two cycles earlier");
        end

    // one strobe per symbol, for its first valid sample once acquired
    symbol_strobe: assert property (@(posedge clk_i) disable iff (!reset_ni)
        symbol_start_o == $past(s_axis_in_tvalid_i && (sample_cnt_i == sample_cnt_t'(0))
                                && (sync_state_o != WAIT_FOR_SSB)))
        else begin
            fail_cnt++;
            $error("symbol start strobe not at the first sample of a symbol");
        end

    acquire_state: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (sync_state_o == WAIT_FOR_SSB) && n_id_2_valid_i |=>
        (sync_state_o == WAIT_FOR_IBAR) && ssb_start_o)
        else begin
            fail_cnt++;
            $error("acquisition did not move to WAIT_FOR_IBAR");
        end

    acquire_mode: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (pss_detector_mode_o == PSS_SEARCH) && n_id_2_valid_i |-> ##2
        (pss_detector_mode_o == PSS_PAUSE))
        else begin
            fail_cnt++;
            $error("PSS mode did not pause after acquisition");
        end

    symbol_length: assert property (@(posedge clk_i) disable iff (!reset_ni)
        m_axis_out_tvalid_o && m_axis_out_tlast_o && clean_q |->
        (seen_q + 1 == FFT_LEN + int'(m_axis_out_tuser_o[4:0])))
        else begin
            fail_cnt++;
            $error("symbol length does not match its CP");
        end

    cp_rule: assert property (@(posedge clk_i) disable iff (!reset_ni)
        m_axis_out_tvalid_o |-> int'(m_axis_out_tuser_o[4:0]) == cp_for(m_axis_out_tuser_o[8:5]))
        else begin
            fail_cnt++;
            $error("CP length does not follow the symbol number");
        end

    symbol_advance: assert property (@(posedge clk_i) disable iff (!reset_ni)
        m_axis_out_tvalid_o && first_q && clean_q |-> m_axis_out_tuser_o[23:5] == next_id_q)
        else begin
            fail_cnt++;
            $error("symbol number did not advance by one");
        end

    ibar_shift: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (sync_state_o == WAIT_FOR_IBAR) && ibar_ssb_valid_i && !s_axis_in_tvalid_i |=>
        {sfn_i, sf_i, sym_i} == add_syms($past(sfn_i), $past(sf_i), $past(sym_i),
                                         int'(IBAR_OFFSET[$past(ibar_ssb_i[1:0])])))
        else begin
            fail_cnt++;
            $error("ibar correction gave the wrong symbol");
        end

    ssb_on_time: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (sync_state_o == SYNCED) && find_i && n_id_2_valid_i |=>
        (sync_state_o == SYNCED) && ssb_start_o)
        else begin
            fail_cnt++;
            $error("on-time SSB not accepted");
        end

    find_to_pause: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (pss_detector_mode_o == PSS_FIND) && n_id_2_valid_i |-> ##2
        (pss_detector_mode_o == PSS_PAUSE))
        else begin
            fail_cnt++;
            $error("PSS mode did not return to pause");
        end

    ssb_lost: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (sync_state_o == SYNCED) && find_i && !n_id_2_valid_i && s_axis_in_tvalid_i
        && (sample_cnt_i == sample_cnt_t'(LOST_SAMPLE)) |=> (sync_state_o == WAIT_FOR_SSB))
        else begin
            fail_cnt++;
            $error("lost SSB did not drop sync");
        end

    missed_count: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (pss_detector_mode_o == PSS_SEARCH) && ($past(pss_detector_mode_o) == PSS_FIND) |->
        (missed_ssbs_o == $past(missed_ssbs_o, 2) + 16'd1))
        else begin
            fail_cnt++;
            $error("missed SSB count did not increment");
        end

endmodule

bind frame_sync_top frame_sync_asserts u_asserts (
    .clk_i               (clk_i),
    .reset_ni            (reset_ni),
    .s_axis_in_tdata_i   (s_axis_in_tdata_i),
    .s_axis_in_tvalid_i  (s_axis_in_tvalid_i),
    .n_id_2_valid_i      (n_id_2_valid_i),
    .ibar_ssb_i          (ibar_ssb_i),
    .ibar_ssb_valid_i    (ibar_ssb_valid_i),
    .pss_detector_mode_o (pss_detector_mode_o),
    .missed_ssbs_o       (missed_ssbs_o),
    .sync_state_o        (sync_state_o),
    .ssb_start_o         (ssb_start_o),
    .m_axis_out_tdata_o  (m_axis_out_tdata_o),
    .m_axis_out_tuser_o  (m_axis_out_tuser_o),
    .m_axis_out_tlast_o  (m_axis_out_tlast_o),
    .m_axis_out_tvalid_o (m_axis_out_tvalid_o),
    .symbol_start_o      (symbol_start_o),
    .find_i              (find),
    .sample_cnt_i        (sample_cnt),
    .sym_i               (sym),
    .sf_i                (sf),
    .sfn_i               (sfn)
);

`default_nettype wire

//--- tb/frame_sync_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sync_tb
    import frame_sync_pkg::*;
;

    // samples in one 20 ms SSB period, 20 subframes with two long CPs each
    localparam int SAMPLES_20MS = SF_PER_FRAME
        * (SYM_PER_SF * FFT_LEN + 2 * CP1_LEN + (SYM_PER_SF - 2) * CP2_LEN);

    logic        clk = 1'b0;
    logic        reset_n;
    sample_t     tdata;
    logic        tvalid;
    nid2_t       n_id_2;
    logic        n_id_2_valid;
    ibar_t       ibar;
    logic        ibar_valid;
    pss_mode_e   pss_mode;
    logic [15:0] missed_ssbs;
    sync_state_e sync_state;
    logic        ssb_start;
    sample_t     out_tdata;
    user_t       out_tuser;
    logic        out_tlast;
    logic        out_tvalid;
    logic        symbol_start;

    logic [31:0] lcg_state = 32'd15885;
    int          value_errors = 0;
    int          timeouts = 0;
    int          samples_since_ssb = 0;

    frame_sync_top UUT (
        .clk_i               (clk),
        .reset_ni            (reset_n),
        .s_axis_in_tdata_i   (tdata),
        .s_axis_in_tvalid_i  (tvalid),
        .n_id_2_i            (n_id_2),
        .n_id_2_valid_i      (n_id_2_valid),
        .ibar_ssb_i          (ibar),
        .ibar_ssb_valid_i    (ibar_valid),
        .pss_detector_mode_o (pss_mode),
        .missed_ssbs_o       (missed_ssbs),
        .sync_state_o        (sync_state),
        .ssb_start_o         (ssb_start),
        .m_axis_out_tdata_o  (out_tdata),
        .m_axis_out_tuser_o  (out_tuser),
        .m_axis_out_tlast_o  (out_tlast),
        .m_axis_out_tvalid_o (out_tvalid),
        .symbol_start_o      (symbol_start)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic finish_run();
        int asserts_failed;
        asserts_failed = UUT.u_asserts.fail_cnt;
        $display("errors: %0d value, %0d timeout, %0d assertion",
                 value_errors, timeouts, asserts_failed);
        if ((value_errors + timeouts + asserts_failed) == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    // one valid sample, preceded by the rare idle cycles the LCG asks for
    task automatic drive_sample(input logic ssb);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            lcg_state = lcg_next(lcg_state);
            n_id_2_valid = 1'b0;
            ibar_valid = 1'b0;
            if (!ssb && (lcg_state[24:16] == 9'd0)) begin
                tvalid = 1'b0;
            end else begin
                tvalid = 1'b1;
                tdata = lcg_state;
                n_id_2_valid = ssb;
                n_id_2 = lcg_state[1:0];
                samples_since_ssb = ssb ? 1 : samples_since_ssb + 1;
                done = 1'b1;
            end
        end
    endtask

    task automatic send_samples(input int n);
        repeat (n) drive_sample(1'b0);
    endtask

    // ibar goes out in an idle cycle so no symbol end coincides with it
    task automatic send_ibar(input ibar_t value);
        @(negedge clk);
        tvalid = 1'b0;
        n_id_2_valid = 1'b0;
        ibar = value;
        ibar_valid = 1'b1;
    endtask

    task automatic run_to_next_ssb();
        while (samples_since_ssb < SAMPLES_20MS) begin
            drive_sample(1'b0);
        end
        drive_sample(1'b1);
    endtask

    task automatic wait_sync_state(input sync_state_e st, input int limit, input string what);
        int n;
        n = 0;
        while ((sync_state != st) && (n < limit)) begin
            drive_sample(1'b0);
            n++;
        end
        if (sync_state != st) begin
            $display("timed out waiting for %s", what);
            timeouts++;
            finish_run();
        end
    endtask

    task automatic wait_pss_mode(input pss_mode_e mode, input int limit, input string what);
        int n;
        n = 0;
        while ((pss_mode != mode) && (n < limit)) begin
            drive_sample(1'b0);
            n++;
        end
        if (pss_mode != mode) begin
            $display("timed out waiting for %s", what);
            timeouts++;
            finish_run();
        end
    endtask

    initial begin
        reset_n = 1'b0;
        tdata = '0;
        tvalid = 1'b0;
        n_id_2 = '0;
        n_id_2_valid = 1'b0;
        ibar = '0;
        ibar_valid = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // first acquisition with ibar 1, then one SSB right on time
        send_samples(300);
        drive_sample(1'b1);
        wait_sync_state(WAIT_FOR_IBAR, 10, "WAIT_FOR_IBAR after first SSB");
        send_samples(100);
        send_ibar(3'd1);
        wait_sync_state(SYNCED, 10, "SYNCED after ibar 1");
        run_to_next_ssb();
        send_samples(2000);

        // the next SSB never comes
        wait_sync_state(WAIT_FOR_SSB, SAMPLES_20MS + 2000, "loss of sync");
        wait_pss_mode(PSS_SEARCH, 2000, "PSS search after a missed SSB");
        check_value("missed_ssbs", 1, int'(missed_ssbs));

        // fresh acquisition with ibar 3
        send_samples(300);
        drive_sample(1'b1);
        wait_sync_state(WAIT_FOR_IBAR, 10, "WAIT_FOR_IBAR after second acquisition");
        send_samples(100);
        send_ibar(3'd3);
        wait_sync_state(SYNCED, 10, "SYNCED after ibar 3");
        send_samples(2000);
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

`default_nettype wire
